// ==== compile.f ====
+incdir+include
hdl/lane_vrf_pkg.sv
hdl/lane_isa_pkg.sv
hdl/lane_sequencer.sv
hdl/vector_regfile.sv
hdl/lane_alu.sv
hdl/lane.sv
testbench/lane_clock_gen.sv
testbench/lane_asserts.sv
testbench/lane_tb.sv

// ==== testbench/lane_tb.sv ====
////////////////////////////////////////
// Lane testbench. Inputs change on the falling edge.
// Only registers loaded here are ever read back.
////////////////////////////////////////

`timescale 1ns/1ps

`include "lane_params.svh"

module lane_tb;

  // Loads and instructions issued below, used for the watchdog
  localparam int NumOps     = 42;
  localparam int OpCycles   = 3 * `LANE_VL_MAX + 4;
  localparam int WatchdogNs = NumOps * OpCycles * 40 * 2;

  logic                     clk;
  logic                     rst_n;
  lane_isa_pkg::lane_insn_t insn;
  logic                     insn_valid;
  logic                     insn_ready;
  logic                     insn_done;
  lane_isa_pkg::ldu_write_t ldu;
  logic                     ldu_gnt;
  lane_vrf_pkg::elem_t      stu_operand;
  logic                     stu_valid;
  logic                     stu_ready;

  integer                   seed;
  logic                     backpressure;
  string                    cur_test;
  lane_vrf_pkg::elem_t      exp_q[$];
  lane_vrf_pkg::elem_t      shadow [`LANE_NR_VREGS][`LANE_VL_MAX];

  lane_clock_gen clk_gen0 (
    .clk_o (clk  ),
    .rst_no(rst_n)
  );

  lane dut0 (
    .clk_i        (clk        ),
    .rst_ni       (rst_n      ),
    .insn_i       (insn       ),
    .insn_valid_i (insn_valid ),
    .insn_ready_o (insn_ready ),
    .insn_done_o  (insn_done  ),
    .ldu_i        (ldu        ),
    .ldu_gnt_o    (ldu_gnt    ),
    .stu_operand_o(stu_operand),
    .stu_valid_o  (stu_valid  ),
    .stu_ready_i  (stu_ready  )
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Element rule of each op, applied below vl only
  function automatic void lane_ref_exec(input lane_isa_pkg::lane_insn_t insn_w);
    lane_vrf_pkg::elem_t a;
    lane_vrf_pkg::elem_t b;
    lane_vrf_pkg::elem_t r;
    if (insn_w.op == lane_isa_pkg::OP_VST) begin
      return;
    end
    for (int e = 0; e < int'(insn_w.vl); e++) begin
      a = shadow[insn_w.vs2][e];
      b = shadow[insn_w.vs1][e];
      case (insn_w.op)
        lane_isa_pkg::OP_VADD:    r = a + b;
        lane_isa_pkg::OP_VSUB:    r = a - b;
        lane_isa_pkg::OP_VAND:    r = a & b;
        lane_isa_pkg::OP_VOR:     r = a | b;
        lane_isa_pkg::OP_VXOR:    r = a ^ b;
        default:                  r = a + insn_w.scalar;
      endcase
      shadow[insn_w.vd][e] = r;
    end
  endfunction

  // Cycles from acceptance to done
  function automatic int done_latency(input lane_vrf_pkg::vl_t vl);
    return (vl == '0) ? 1 : int'(vl) + 2;
  endfunction

  task automatic check_elem(input string name, input lane_vrf_pkg::elem_t exp,
                            input lane_vrf_pkg::elem_t act);
    if (exp !== act) begin
      stop_run($sformatf("Fail %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input lane_vrf_pkg::vl_t vl,
                               input int exp_cycles, input int act_cycles);
    if (exp_cycles != act_cycles) begin
      stop_run($sformatf("Fail %s: vl %0d expected %0d cycles, actual %0d cycles",
                         name, vl, exp_cycles, act_cycles));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic load_vreg(input lane_vrf_pkg::vreg_idx_t vreg);
    lane_vrf_pkg::elem_t data;
    logic                granted;
    for (int e = 0; e < `LANE_VL_MAX; e++) begin
      data    = $random(seed);
      granted = 1'b0;
      // Hold the write until it is granted
      while (!granted) begin
        @(negedge clk);
        ldu.valid     = 1'b1;
        ldu.addr.vreg = vreg;
        ldu.addr.elem = lane_vrf_pkg::elem_idx_t'(e);
        ldu.wdata     = data;
        granted       = ldu_gnt;
      end
      shadow[vreg][e] = data;
    end
    @(negedge clk);
    ldu.valid = 1'b0;
  endtask

  // Returns at the falling edge inside the done cycle
  task automatic issue_insn(input lane_isa_pkg::lane_insn_t insn_w, output int cycles);
    @(negedge clk);
    while (!insn_ready) begin
      @(negedge clk);
    end
    insn       = insn_w;
    insn_valid = 1'b1;
    @(negedge clk);
    insn_valid = 1'b0;
    cycles     = 1;
    while (!insn_done) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_alu(input string name, input lane_isa_pkg::lane_op_e op,
                         input lane_vrf_pkg::vreg_idx_t vd,
                         input lane_vrf_pkg::vreg_idx_t vs1,
                         input lane_vrf_pkg::vreg_idx_t vs2,
                         input lane_vrf_pkg::vl_t vl, input lane_vrf_pkg::elem_t scalar);
    lane_isa_pkg::lane_insn_t insn_w;
    int                       cycles;
    insn_w.op     = op;
    insn_w.vd     = vd;
    insn_w.vs1    = vs1;
    insn_w.vs2    = vs2;
    insn_w.vl     = vl;
    insn_w.scalar = scalar;
    issue_insn(insn_w, cycles);
    lane_ref_exec(insn_w);
    check_latency(name, vl, done_latency(vl), cycles);
  endtask

  // Full-length store, checked by the compare process
  task automatic store_vreg(input string name, input lane_vrf_pkg::vreg_idx_t vreg);
    lane_isa_pkg::lane_insn_t insn_w;
    int                       cycles;
    cur_test = name;
    for (int e = 0; e < `LANE_VL_MAX; e++) begin
      exp_q.push_back(shadow[vreg][e]);
    end
    insn_w     = '0;
    insn_w.op  = lane_isa_pkg::OP_VST;
    insn_w.vs2 = vreg;
    insn_w.vl  = lane_vrf_pkg::vl_t'(`LANE_VL_MAX);
    issue_insn(insn_w, cycles);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("Store of v%0d in %s ended with %0d elements missing",
                         vreg, name, exp_q.size()));
    end
  endtask

  ////////////////////////////////////////
  // Processes
  ////////////////////////////////////////

  initial begin : drive_ready
    forever begin
      @(negedge clk);
      stu_ready = backpressure ? (($random(seed) & 1) != 0) : 1'b1;
    end
  end

  initial begin : compare_stores
    forever begin
      @(posedge clk);
      if (rst_n && stu_valid && stu_ready) begin
        if (exp_q.size() == 0) begin
          stop_run("Store port sent an element that no store asked for");
        end else begin
          check_elem(cur_test, exp_q.pop_front(), stu_operand);
        end
      end
    end
  end

  initial begin : watch_asserts
    wait (dut0.i_lane_sequencer.u_asserts.fail_count != 0);
    stop_run("A protocol assertion on the sequencer failed");
  end

  initial begin : watchdog
    #(WatchdogNs);
    stop_run($sformatf("Timeout: the tests did not finish within %0d ns", WatchdogNs));
  end

  initial begin : stimulus
    lane_isa_pkg::lane_op_e op;
    lane_vrf_pkg::vl_t      vl;
    lane_vrf_pkg::elem_t    scalar;
    int                     op_idx;
    seed         = 32'h43d1_eae4;
    insn         = '0;
    insn_valid   = 1'b0;
    ldu          = '0;
    stu_ready    = 1'b1;
    backpressure = 1'b0;
    @(posedge rst_n);

    // Load and store round trip
    for (int r = 1; r <= 4; r++) begin
      load_vreg(lane_vrf_pkg::vreg_idx_t'(r));
      store_vreg("round_trip", lane_vrf_pkg::vreg_idx_t'(r));
    end

    // Vector-vector ops on v2 and v1
    for (int i = 0; i < 5; i++) begin
      op = lane_isa_pkg::lane_op_e'(i);
      run_alu($sformatf("vv_%s", op.name()), op, lane_vrf_pkg::vreg_idx_t'(10 + i),
              5'd1, 5'd2, 4'd8, '0);
      store_vreg($sformatf("vv_%s", op.name()), lane_vrf_pkg::vreg_idx_t'(10 + i));
    end

    // Scalar add, vs1 points at unrelated data
    scalar = $random(seed);
    run_alu("vx_add", lane_isa_pkg::OP_VADD_VX, 5'd15, 5'd4, 5'd3, 4'd8, scalar);
    store_vreg("vx_add", 5'd15);

    // Partial vl into freshly loaded destinations
    for (int t = 0; t < 6; t++) begin
      load_vreg(lane_vrf_pkg::vreg_idx_t'(20 + t));
      op_idx = ($random(seed) & 32'h7fff_ffff) % 6;
      op     = lane_isa_pkg::lane_op_e'(op_idx);
      // First case is always the empty vector
      vl     = (t == 0) ? '0 : lane_vrf_pkg::vl_t'($random(seed) & 7);
      scalar = $random(seed);
      run_alu($sformatf("partial_%s_vl%0d", op.name(), vl), op,
              lane_vrf_pkg::vreg_idx_t'(20 + t), 5'd1, 5'd2, vl, scalar);
      store_vreg($sformatf("partial_%s_vl%0d", op.name(), vl),
                 lane_vrf_pkg::vreg_idx_t'(20 + t));
    end

    // Random store back-pressure
    @(posedge clk);
    backpressure = 1'b1;
    store_vreg("backpressure", 5'd1);
    store_vreg("backpressure", 5'd10);
    store_vreg("backpressure", 5'd15);
    store_vreg("backpressure", 5'd20);
    @(posedge clk);
    backpressure = 1'b0;

    if (dut0.i_lane_sequencer.u_asserts.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_run("A protocol assertion on the sequencer failed");
    end
  end

endmodule

// ==== testbench/lane_asserts.sv ====
////////////////////////////////////////
// Protocol checks on the sequencer ports.
// fail_count is read by the testbench.
////////////////////////////////////////

`timescale 1ns/1ps

module lane_asserts (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     insn_valid_i,
  input logic                     insn_ready_i,
  input logic                     insn_done_i,
  input logic                     ldu_gnt_i,
  input lane_vrf_pkg::vrf_write_t alu_wb_i,
  input lane_vrf_pkg::elem_t      stu_operand_i,
  input logic                     stu_valid_i,
  input logic                     stu_ready_i
);

  int unsigned fail_count = 0;

  // Store data holds until the transfer
  stu_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      stu_valid_i && !stu_ready_i |=> stu_valid_i && $stable(stu_operand_i))
    else begin
      $error("store operand or valid changed before the transfer");
      fail_count++;
    end

  // Busy from acceptance up to and including done
  busy_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      insn_valid_i && insn_ready_i |=> !insn_ready_i)
    else begin
      $error("lane ready right after accepting an instruction");
      fail_count++;
    end

  busy_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !insn_ready_i && !insn_done_i |=> !insn_ready_i)
    else begin
      $error("lane ready again before done");
      fail_count++;
    end

  // No load grant while an ALU result still needs the write port
  no_gnt_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ldu_gnt_i |-> !alu_wb_i.valid)
    else begin
      $error("load granted while an ALU result is written back");
      fail_count++;
    end

endmodule

bind lane_sequencer lane_asserts u_asserts (
  .clk_i        (clk_i        ),
  .rst_ni       (rst_ni       ),
  .insn_valid_i (insn_valid_i ),
  .insn_ready_i (insn_ready_o ),
  .insn_done_i  (insn_done_o  ),
  .ldu_gnt_i    (ldu_gnt_o    ),
  .alu_wb_i     (alu_wb_i     ),
  .stu_operand_i(stu_operand_o),
  .stu_valid_i  (stu_valid_o  ),
  .stu_ready_i  (stu_ready_i  )
);

// ==== testbench/lane_clock_gen.sv ====
////////////////////////////////////////
// 40 ns clock, reset low for the first two rising edges
////////////////////////////////////////

`timescale 1ns/1ps

module lane_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== hdl/lane.sv ====
////////////////////////////////////////
// One lane: sequencer, register file and integer ALU.
// Loads are accepted only while no instruction runs.
////////////////////////////////////////

`timescale 1ns/1ps

module lane (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction port
  input  lane_isa_pkg::lane_insn_t insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output logic                     insn_done_o,
  // Load port
  input  lane_isa_pkg::ldu_write_t ldu_i,
  output logic                     ldu_gnt_o,
  // Store port
  output lane_vrf_pkg::elem_t      stu_operand_o,
  output logic                     stu_valid_o,
  input  logic                     stu_ready_i
);

  lane_vrf_pkg::vrf_read_req_t rd_req;
  lane_vrf_pkg::vrf_write_t    vrf_wr;
  lane_vrf_pkg::vrf_write_t    alu_wb;
  lane_vrf_pkg::elem_t         rdata1;
  lane_vrf_pkg::elem_t         rdata2;
  lane_isa_pkg::lane_op_e      alu_op;
  lane_vrf_pkg::elem_t         alu_scalar;
  logic                        alu_start;
  logic                        alu_rd_valid;
  lane_vrf_pkg::vrf_addr_t     alu_vd_addr;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  lane_sequencer i_lane_sequencer (
    .clk_i         (clk_i        ),
    .rst_ni        (rst_ni       ),
    .insn_i        (insn_i       ),
    .insn_valid_i  (insn_valid_i ),
    .insn_ready_o  (insn_ready_o ),
    .insn_done_o   (insn_done_o  ),
    .ldu_i         (ldu_i        ),
    .ldu_gnt_o     (ldu_gnt_o    ),
    .rd_req_o      (rd_req       ),
    .rdata2_i      (rdata2       ),
    .vrf_wr_o      (vrf_wr       ),
    .alu_op_o      (alu_op       ),
    .alu_scalar_o  (alu_scalar   ),
    .alu_start_o   (alu_start    ),
    .alu_rd_valid_o(alu_rd_valid ),
    .alu_vd_addr_o (alu_vd_addr  ),
    .alu_wb_i      (alu_wb       ),
    .stu_operand_o (stu_operand_o),
    .stu_valid_o   (stu_valid_o  ),
    .stu_ready_i   (stu_ready_i  )
  );

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  vector_regfile i_vrf (
    .clk_i   (clk_i ),
    .rst_ni  (rst_ni),
    .rd_req_i(rd_req),
    .wr_i    (vrf_wr),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2)
  );

  lane_alu i_alu (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .start_i     (alu_start   ),
    .op_i        (alu_op      ),
    .scalar_i    (alu_scalar  ),
    .rd_valid_i  (alu_rd_valid),
    .rd_vd_addr_i(alu_vd_addr ),
    .rdata1_i    (rdata1      ),
    .rdata2_i    (rdata2      ),
    .wb_o        (alu_wb      )
  );

endmodule

// ==== hdl/lane_alu.sv ====
////////////////////////////////////////
// Single registered integer stage, no back-pressure.
// Op and scalar stay fixed for the whole instruction.
////////////////////////////////////////

`timescale 1ns/1ps

module lane_alu (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Operation, latched on start
  input  logic                     start_i,
  input  lane_isa_pkg::lane_op_e   op_i,
  input  lane_vrf_pkg::elem_t      scalar_i,
  // Operands, aligned with the register file output
  input  logic                     rd_valid_i,
  input  lane_vrf_pkg::vrf_addr_t  rd_vd_addr_i,
  input  lane_vrf_pkg::elem_t      rdata1_i,
  input  lane_vrf_pkg::elem_t      rdata2_i,
  // Write-back
  output lane_vrf_pkg::vrf_write_t wb_o
);

  lane_isa_pkg::lane_op_e  op_q;
  lane_vrf_pkg::elem_t     scalar_q;
  lane_vrf_pkg::elem_t     result;

  logic                    wb_valid_q;
  lane_vrf_pkg::vrf_addr_t wb_addr_q;
  lane_vrf_pkg::elem_t     wb_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= lane_isa_pkg::OP_VADD;
    end else if (start_i) begin
      op_q <= op_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      scalar_q <= scalar_i;
    end
  end

  // vs2 is the left operand, subtraction wraps
  always_comb begin
    case (op_q)
      lane_isa_pkg::OP_VADD:    result = rdata2_i + rdata1_i;
      lane_isa_pkg::OP_VSUB:    result = rdata2_i - rdata1_i;
      lane_isa_pkg::OP_VAND:    result = rdata2_i & rdata1_i;
      lane_isa_pkg::OP_VOR:     result = rdata2_i | rdata1_i;
      lane_isa_pkg::OP_VXOR:    result = rdata2_i ^ rdata1_i;
      lane_isa_pkg::OP_VADD_VX: result = rdata2_i + scalar_q;
      default:                  result = rdata2_i;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= rd_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_addr_q <= rd_vd_addr_i;
    wb_data_q <= result;
  end

  assign wb_o = '{valid: wb_valid_q, addr: wb_addr_q, data: wb_data_q};

endmodule

// ==== hdl/vector_regfile.sv ====
////////////////////////////////////////
// Two registered read ports, one write port. A read of the address
// written in the same cycle returns the old value.
////////////////////////////////////////

`timescale 1ns/1ps

`include "lane_params.svh"

module vector_regfile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read request, data one cycle later
  input  lane_vrf_pkg::vrf_read_req_t rd_req_i,
  // Element write
  input  lane_vrf_pkg::vrf_write_t    wr_i,
  output lane_vrf_pkg::elem_t         rdata1_o,
  output lane_vrf_pkg::elem_t         rdata2_o
);

  localparam int unsigned Depth = `LANE_NR_VREGS * `LANE_VL_MAX;

  lane_vrf_pkg::elem_t mem [Depth];

  lane_vrf_pkg::elem_t rdata1_q;
  lane_vrf_pkg::elem_t rdata2_q;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Register number in the upper bits, element in the lower
  always_ff @(posedge clk_i) begin
    if (wr_i.valid) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Outputs hold between requests
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata1_q <= '0;
      rdata2_q <= '0;
    end else if (rd_req_i.valid) begin
      rdata1_q <= mem[rd_req_i.vs1];
      rdata2_q <= mem[rd_req_i.vs2];
    end
  end

  assign rdata1_o = rdata1_q;
  assign rdata2_o = rdata2_q;

endmodule

// ==== hdl/lane_sequencer.sv ====
////////////////////////////////////////
// Runs one instruction at a time. Loads are granted only while idle,
// so they never collide with ALU write-back.
////////////////////////////////////////

`timescale 1ns/1ps

module lane_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Instruction port
  input  lane_isa_pkg::lane_insn_t   insn_i,
  input  logic                       insn_valid_i,
  output logic                       insn_ready_o,
  output logic                       insn_done_o,
  // Load port
  input  lane_isa_pkg::ldu_write_t   ldu_i,
  output logic                       ldu_gnt_o,
  // Register file
  output lane_vrf_pkg::vrf_read_req_t rd_req_o,
  input  lane_vrf_pkg::elem_t        rdata2_i,
  output lane_vrf_pkg::vrf_write_t   vrf_wr_o,
  // ALU
  output lane_isa_pkg::lane_op_e     alu_op_o,
  output lane_vrf_pkg::elem_t        alu_scalar_o,
  output logic                       alu_start_o,
  output logic                       alu_rd_valid_o,
  output lane_vrf_pkg::vrf_addr_t    alu_vd_addr_o,
  input  lane_vrf_pkg::vrf_write_t   alu_wb_i,
  // Store port
  output lane_vrf_pkg::elem_t        stu_operand_o,
  output logic                       stu_valid_o,
  input  logic                       stu_ready_i
);

  typedef enum logic [2:0] {IDLE, READ, DRAIN, ST_READ, ST_WAIT} state_e;

  state_e                   state_q;
  lane_isa_pkg::lane_insn_t insn_q;
  lane_vrf_pkg::elem_idx_t  cnt_q;
  logic                     drain_q;
  lane_vrf_pkg::elem_t      stu_q;
  logic                     stu_valid_q;
  logic                     rd_valid_q;
  lane_vrf_pkg::vrf_addr_t  vd_addr_q;

  logic accept;
  logic last_elem;
  logic st_capture;
  logic stu_xfer;

  assign insn_ready_o = (state_q == IDLE);
  assign accept       = insn_valid_i & insn_ready_o;
  assign ldu_gnt_o    = insn_ready_o & ~insn_valid_i;
  assign insn_done_o  = (state_q == DRAIN) & drain_q;
  assign last_elem    = (lane_vrf_pkg::vl_t'(cnt_q) + 1'b1) == insn_q.vl;
  assign st_capture   = (state_q == ST_WAIT) & ~stu_valid_q;
  assign stu_xfer     = stu_valid_q & stu_ready_i;

  // Op and scalar go straight from the port, the ALU latches them
  assign alu_op_o     = insn_i.op;
  assign alu_scalar_o = insn_i.scalar;
  assign alu_start_o  = accept & (insn_i.op != lane_isa_pkg::OP_VST);

  // Both operands use the same element index
  assign rd_req_o.valid = (state_q == READ) | (state_q == ST_READ);
  assign rd_req_o.vs1   = '{vreg: insn_q.vs1, elem: cnt_q};
  assign rd_req_o.vs2   = '{vreg: insn_q.vs2, elem: cnt_q};

  assign alu_rd_valid_o = rd_valid_q;
  assign alu_vd_addr_o  = vd_addr_q;
  assign stu_operand_o  = stu_q;
  assign stu_valid_o    = stu_valid_q;

  // Granted load takes the write port, else ALU result
  always_comb begin
    vrf_wr_o = alu_wb_i;
    if (ldu_i.valid && ldu_gnt_o) begin
      vrf_wr_o.valid = 1'b1;
      vrf_wr_o.addr  = ldu_i.addr;
      vrf_wr_o.data  = ldu_i.wdata;
    end
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      drain_q     <= 1'b0;
      stu_valid_q <= 1'b0;
      rd_valid_q  <= 1'b0;
    end else begin
      rd_valid_q <= (state_q == READ);
      case (state_q)
        IDLE: begin
          if (accept) begin
            cnt_q <= '0;
            if (insn_i.vl == '0) begin
              // Nothing to do, done in the next cycle
              state_q <= DRAIN;
              drain_q <= 1'b1;
            end else if (insn_i.op == lane_isa_pkg::OP_VST) begin
              state_q <= ST_READ;
            end else begin
              state_q <= READ;
            end
          end
        end
        READ: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_elem) begin
            state_q <= DRAIN;
            drain_q <= 1'b0;
          end
        end
        // Two cycles for read data and ALU register
        DRAIN: begin
          if (drain_q) begin
            state_q <= IDLE;
            drain_q <= 1'b0;
          end else begin
            drain_q <= 1'b1;
          end
        end
        ST_READ: state_q <= ST_WAIT;
        ST_WAIT: begin
          if (st_capture) begin
            stu_valid_q <= 1'b1;
          end else if (stu_xfer) begin
            stu_valid_q <= 1'b0;
            cnt_q       <= cnt_q + 1'b1;
            if (last_elem) begin
              state_q <= DRAIN;
              drain_q <= 1'b1;
            end else begin
              state_q <= ST_READ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
    if (st_capture) begin
      stu_q <= rdata2_i;
    end
    // Destination lags the read by one cycle
    vd_addr_q <= '{vreg: insn_q.vd, elem: cnt_q};
  end

endmodule

// ==== hdl/lane_isa_pkg.sv ====
////////////////////////////////////////
// Instruction and load port formats of the lane.
// Only one instruction is in flight at a time.
////////////////////////////////////////

package lane_isa_pkg;

  // Supported vector operations
  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,
    OP_VSUB    = 3'd1,
    OP_VAND    = 3'd2,
    OP_VOR     = 3'd3,
    OP_VXOR    = 3'd4,
    OP_VADD_VX = 3'd5,
    OP_VST     = 3'd6
  } lane_op_e;

  // Instruction as issued to the lane
  typedef struct packed {
    lane_op_e                op;
    lane_vrf_pkg::vreg_idx_t vd;
    lane_vrf_pkg::vreg_idx_t vs1;
    lane_vrf_pkg::vreg_idx_t vs2;
    lane_vrf_pkg::vl_t       vl;
    lane_vrf_pkg::elem_t     scalar;
  } lane_insn_t;

  // Single element write from the load unit
  typedef struct packed {
    logic                    valid;
    lane_vrf_pkg::vrf_addr_t addr;
    lane_vrf_pkg::elem_t     wdata;
  } ldu_write_t;

endpackage

// ==== hdl/lane_vrf_pkg.sv ====
////////////////////////////////////////
// Register file types. An address is the register number
// followed by the element index.
////////////////////////////////////////

`include "lane_params.svh"

package lane_vrf_pkg;

  typedef logic [`LANE_ELEN-1:0]                  elem_t;
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0]      vreg_idx_t;
  typedef logic [$clog2(`LANE_VL_MAX)-1:0]        elem_idx_t;
  // Holds 0 up to VL_MAX inclusive
  typedef logic [$clog2(`LANE_VL_MAX + 1)-1:0]    vl_t;

  typedef struct packed {
    vreg_idx_t vreg;
    elem_idx_t elem;
  } vrf_addr_t;

  typedef struct packed {
    logic      valid;
    vrf_addr_t vs1;
    vrf_addr_t vs2;
  } vrf_read_req_t;

  typedef struct packed {
    logic      valid;
    vrf_addr_t addr;
    elem_t     data;
  } vrf_write_t;

endpackage

// ==== include/lane_params.svh ====
////////////////////////////////////////
// Sizes of the single lane. VL_MAX and NR_VREGS must be powers of two,
// since the register file address is a plain concatenation.
////////////////////////////////////////

`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Element width in bits
`define LANE_ELEN 32

////////////////////////////////////////
// Register file geometry
////////////////////////////////////////

`define LANE_NR_VREGS 32
// Elements per vector register, also the largest vl
`define LANE_VL_MAX 8

`endif
